// File: Makefile
# Verilator build and run for the lsu testbench

VERILATOR ?= verilator
TOP       ?= lsu_tb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
FILELIST  ?= compile.f
PASS_MSG  ?= All checks passed

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: compile.f
design/lsu_pkg.sv
design/lsu_request_stage.sv
design/lsu_outstanding_ctrl.sv
design/lsu_response_stage.sv
design/lsu_top.sv
tb/lsu_mem_model.sv
tb/lsu_tb.sv

// File: design/lsu_outstanding_ctrl.sv
// bus issue and outstanding count; needs rvalid at least one cycle after grant, in order
`default_nettype none

module lsu_outstanding_ctrl #(
  parameter int DEPTH = lsu_pkg::DEFAULT_DEPTH  // max accepted, unanswered transactions
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              req_i,
  input  lsu_pkg::bus_req_t bus_req_i,
  output logic              data_req_o,
  input  logic              data_gnt_i,
  input  logic              data_rvalid_i,
  output lsu_pkg::addr_t    data_addr_o,
  output logic              data_we_o,
  output lsu_pkg::be_t      data_be_o,
  output lsu_pkg::data_t    data_wdata_o,
  output logic              ctrl_update_o,
  output logic              lsu_ready_ex_o,
  output logic              lsu_ready_wb_o,
  output logic              busy_o
);

  localparam int CNT_W = $clog2(DEPTH + 1);  // must hold 0..DEPTH

  typedef logic [CNT_W-1:0] cnt_t;

  cnt_t cnt_q;     // transactions granted and still waiting for rvalid
  cnt_t cnt_d;
  logic accepted;  // req and gnt in the same cycle
  logic count_up;
  logic count_down;

  //////////////////////////////////////////////////
  // request issue
  //////////////////////////////////////////////////

  // no rvalid in this path, so req does not wait on the response side
  assign data_req_o   = req_i && (cnt_q < cnt_t'(DEPTH));
  assign accepted     = data_req_o && data_gnt_i;

  // fields are held steady by the caller until the grant
  assign data_addr_o  = bus_req_i.addr;
  assign data_we_o    = bus_req_i.we;
  assign data_be_o    = bus_req_i.be;
  assign data_wdata_o = bus_req_i.wdata;

  //////////////////////////////////////////////////
  // ready and busy
  //////////////////////////////////////////////////

  assign lsu_ready_wb_o = (cnt_q == '0) ? 1'b1 : data_rvalid_i;  // wb free or draining now

  // ex may only move on when wb can take it in the same edge
  assign lsu_ready_ex_o = !req_i                 ? 1'b1 :
                          (cnt_q == '0)          ? accepted :
                          (cnt_q == cnt_t'(1))   ? (data_rvalid_i && accepted) :
                                                   data_rvalid_i;

  assign ctrl_update_o = lsu_ready_ex_o && req_i;  // load wb control from ex

  assign busy_o = (cnt_q != '0) || data_req_o;

  //////////////////////////////////////////////////
  // outstanding counter
  //////////////////////////////////////////////////

  assign count_up   = accepted;
  assign count_down = data_rvalid_i;  // one rvalid per grant

  always_comb begin
    case ({count_up, count_down})
      2'b10:   cnt_d = cnt_q + cnt_t'(1);
      2'b01:   cnt_d = cnt_q - cnt_t'(1);
      default: cnt_d = cnt_q;  // idle, or one in and one out
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

endmodule

`default_nettype wire

// File: design/lsu_pkg.sv
// shared lsu types; 32-bit data bus only, data_type 11 decodes as byte, sign_ext 11 as sign
`default_nettype none

package lsu_pkg;

  //////////////////////////////////////////////////
  // scalar widths
  //////////////////////////////////////////////////

  typedef logic [31:0] addr_t;      // byte address
  typedef logic [31:0] data_t;      // one bus word
  typedef logic [3:0]  be_t;        // one enable per byte lane
  typedef logic [1:0]  byte_off_t;  // byte offset inside a word

  // max accepted but unanswered bus transactions
  localparam int DEFAULT_DEPTH = 2;

  // access size, code 11 falls through to byte everywhere
  typedef enum logic [1:0] {
    WORD = 2'b00,
    HALF = 2'b01,
    BYTE = 2'b10
  } data_type_e;

  // load extension mode, code 11 behaves as sign
  typedef enum logic [1:0] {
    ZERO_EXT = 2'b00,
    SIGN_EXT = 2'b01,
    ONES_EXT = 2'b10
  } sign_ext_e;

  //////////////////////////////////////////////////
  // stage to stage bundles
  //////////////////////////////////////////////////

  // request as presented by the ex stage
  typedef struct packed {
    logic       req;         // access wanted this cycle
    logic       we;          // 1 store, 0 load
    logic       misaligned;  // second part of a split access
    data_type_e data_type;
    sign_ext_e  sign_ext;
    byte_off_t  reg_offset;  // byte lane of store data inside the register
    addr_t      operand_a;
    addr_t      operand_b;
    logic       use_incr;    // address is a + b
    data_t      wdata;
  } ex_req_t;

  // address phase of the data bus
  typedef struct packed {
    addr_t addr;
    logic  we;
    be_t   be;
    data_t wdata;
  } bus_req_t;

  // what wb needs to align the returning word
  typedef struct packed {
    data_type_e data_type;
    byte_off_t  offset;
    sign_ext_e  sign_ext;
    logic       we;
  } wb_ctrl_t;

endpackage

`default_nettype wire

// File: design/lsu_request_stage.sv
// combinational ex stage; a second part must keep the byte offset of its first part
`default_nettype none

module lsu_request_stage (
  input  lsu_pkg::ex_req_t  ex_req_i,
  output lsu_pkg::bus_req_t bus_req_o,
  output lsu_pkg::byte_off_t addr_off_o,
  output logic              misaligned_o
);

  lsu_pkg::addr_t     addr;      // effective byte address
  lsu_pkg::byte_off_t off;
  lsu_pkg::byte_off_t wdata_off; // lanes to rotate store data by
  lsu_pkg::be_t       be;
  lsu_pkg::data_t     wdata_rot;

  //////////////////////////////////////////////////
  // address
  //////////////////////////////////////////////////

  assign addr = ex_req_i.use_incr ? (ex_req_i.operand_a + ex_req_i.operand_b)
                                  : ex_req_i.operand_a;
  assign off  = addr[1:0];

  // a first-part word off the boundary, or a halfword crossing into the next word
  always_comb begin
    misaligned_o = 1'b0;
    if (ex_req_i.req && !ex_req_i.misaligned) begin
      case (ex_req_i.data_type)
        lsu_pkg::WORD: misaligned_o = (off != 2'b00);
        lsu_pkg::HALF: misaligned_o = (off == 2'b11);
        default:       misaligned_o = 1'b0;  // bytes never split
      endcase
    end
  end

  //////////////////////////////////////////////////
  // byte enables
  //////////////////////////////////////////////////

  always_comb begin
    case (ex_req_i.data_type)
      lsu_pkg::WORD: begin
        if (!ex_req_i.misaligned) begin  // first part, upper lanes of this word
          case (off)
            2'b00:   be = 4'b1111;
            2'b01:   be = 4'b1110;
            2'b10:   be = 4'b1100;
            default: be = 4'b1000;
          endcase
        end else begin  // second part, low lanes of the next word
          case (off)
            2'b00:   be = 4'b0000;  // cannot happen
            2'b01:   be = 4'b0001;
            2'b10:   be = 4'b0011;
            default: be = 4'b0111;
          endcase
        end
      end
      lsu_pkg::HALF: begin
        if (!ex_req_i.misaligned) begin
          case (off)
            2'b00:   be = 4'b0011;
            2'b01:   be = 4'b0110;
            2'b10:   be = 4'b1100;
            default: be = 4'b1000;  // low byte only, top byte follows
          endcase
        end else begin
          be = 4'b0001;
        end
      end
      default: begin  // byte, also code 11
        case (off)
          2'b00:   be = 4'b0001;
          2'b01:   be = 4'b0010;
          2'b10:   be = 4'b0100;
          default: be = 4'b1000;
        endcase
      end
    endcase
  end

  //////////////////////////////////////////////////
  // store data lane rotation
  //////////////////////////////////////////////////

  assign wdata_off = off - ex_req_i.reg_offset;  // wraps mod 4

  always_comb begin
    case (wdata_off)  // rotate left by whole bytes
      2'b00:   wdata_rot = ex_req_i.wdata;
      2'b01:   wdata_rot = {ex_req_i.wdata[23:0], ex_req_i.wdata[31:24]};
      2'b10:   wdata_rot = {ex_req_i.wdata[15:0], ex_req_i.wdata[31:16]};
      default: wdata_rot = {ex_req_i.wdata[7:0], ex_req_i.wdata[31:8]};
    endcase
  end

  // second part always goes to the start of the next word
  assign bus_req_o.addr  = ex_req_i.misaligned ? {addr[31:2], 2'b00} : addr;
  assign bus_req_o.we    = ex_req_i.we;
  assign bus_req_o.be    = be;
  assign bus_req_o.wdata = wdata_rot;
  assign addr_off_o      = off;

endmodule

`default_nettype wire

// File: design/lsu_response_stage.sv
// wb alignment; split loads need the caller's misaligned flags live at each rvalid
`default_nettype none

module lsu_response_stage (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              ctrl_update_i,
  input  lsu_pkg::wb_ctrl_t wb_ctrl_i,
  input  logic              misaligned_ex_i,  // ex is on the second part
  input  logic              misaligned_i,     // ex just found a split access
  input  logic              data_rvalid_i,
  input  lsu_pkg::data_t    data_rdata_i,
  output lsu_pkg::data_t    rdata_o
);

  lsu_pkg::wb_ctrl_t ctrl_q;   // control of the access in flight
  lsu_pkg::data_t    hold_q;   // first-part raw word or last result
  lsu_pkg::data_t    rdata_w;  // word, possibly joined across two beats
  lsu_pkg::data_t    rdata_h;
  lsu_pkg::data_t    rdata_b;
  lsu_pkg::data_t    rdata_ext;
  logic [15:0]       half_raw;
  logic [7:0]        byte_raw;

  // fill bit for the upper part of an extended load
  function automatic logic fill_bit(lsu_pkg::sign_ext_e mode, logic msb);
    case (mode)
      lsu_pkg::ZERO_EXT: fill_bit = 1'b0;
      lsu_pkg::ONES_EXT: fill_bit = 1'b1;
      default:           fill_bit = msb;  // sign, also code 11
    endcase
  endfunction

  //////////////////////////////////////////////////
  // wb control register
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ctrl_q <= '0;
    end else if (ctrl_update_i) begin  // ex hands its access to wb
      ctrl_q <= wb_ctrl_i;
    end
  end

  //////////////////////////////////////////////////
  // alignment and extension
  //////////////////////////////////////////////////

  // new beat supplies the low lanes, hold_q the tail of the first part
  always_comb begin
    case (ctrl_q.offset)
      2'b00:   rdata_w = data_rdata_i;
      2'b01:   rdata_w = {data_rdata_i[7:0], hold_q[31:8]};
      2'b10:   rdata_w = {data_rdata_i[15:0], hold_q[31:16]};
      default: rdata_w = {data_rdata_i[23:0], hold_q[31:24]};
    endcase
  end

  always_comb begin
    case (ctrl_q.offset)
      2'b00:   half_raw = data_rdata_i[15:0];
      2'b01:   half_raw = data_rdata_i[23:8];
      2'b10:   half_raw = data_rdata_i[31:16];
      default: half_raw = {data_rdata_i[7:0], hold_q[31:24]};  // crosses the word
    endcase
  end

  always_comb begin
    case (ctrl_q.offset)
      2'b00:   byte_raw = data_rdata_i[7:0];
      2'b01:   byte_raw = data_rdata_i[15:8];
      2'b10:   byte_raw = data_rdata_i[23:16];
      default: byte_raw = data_rdata_i[31:24];
    endcase
  end

  assign rdata_h = {{16{fill_bit(ctrl_q.sign_ext, half_raw[15])}}, half_raw};
  assign rdata_b = {{24{fill_bit(ctrl_q.sign_ext, byte_raw[7])}}, byte_raw};

  always_comb begin
    case (ctrl_q.data_type)
      lsu_pkg::WORD: rdata_ext = rdata_w;
      lsu_pkg::HALF: rdata_ext = rdata_h;
      default:       rdata_ext = rdata_b;  // byte, also code 11
    endcase
  end

  //////////////////////////////////////////////////
  // holding register
  //////////////////////////////////////////////////

  // raw word while a split load is between its parts, else the finished value
  always_ff @(posedge clk) begin
    if (data_rvalid_i && !ctrl_q.we) begin
      if (misaligned_ex_i || misaligned_i) begin
        hold_q <= data_rdata_i;
      end else begin
        hold_q <= rdata_ext;
      end
    end
  end

  assign rdata_o = data_rvalid_i ? rdata_ext : hold_q;  // last value stays visible

endmodule

`default_nettype wire

// File: design/lsu_top.sv
// lsu top; caller holds ex_req_i steady until lsu_ready_ex_o and drives both split parts
`default_nettype none

module lsu_top #(
  parameter int DEPTH = lsu_pkg::DEFAULT_DEPTH  // max in-flight bus transactions
) (
  input  logic              clk,
  input  logic              rst_n,
  input  lsu_pkg::ex_req_t  ex_req_i,
  output logic              data_misaligned_o,
  output lsu_pkg::data_t    data_rdata_ex_o,
  output logic              lsu_ready_ex_o,
  output logic              lsu_ready_wb_o,
  output logic              busy_o,
  // data bus
  output logic              data_req_o,
  input  logic              data_gnt_i,
  input  logic              data_rvalid_i,
  output lsu_pkg::addr_t    data_addr_o,
  output logic              data_we_o,
  output lsu_pkg::be_t      data_be_o,
  output lsu_pkg::data_t    data_wdata_o,
  input  lsu_pkg::data_t    data_rdata_i
);

  lsu_pkg::bus_req_t  bus_req;      // address phase from ex
  lsu_pkg::byte_off_t addr_off;     // unaligned byte offset
  lsu_pkg::wb_ctrl_t  wb_ctrl;
  logic               ctrl_update;  // ex to wb handover

  //////////////////////////////////////////////////
  // ex side
  //////////////////////////////////////////////////

  lsu_request_stage u_req (
    .ex_req_i     (ex_req_i),
    .bus_req_o    (bus_req),
    .addr_off_o   (addr_off),
    .misaligned_o (data_misaligned_o)
  );

  lsu_outstanding_ctrl #(
    .DEPTH (DEPTH)
  ) u_out (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (ex_req_i.req),
    .bus_req_i      (bus_req),
    .data_req_o     (data_req_o),
    .data_gnt_i     (data_gnt_i),
    .data_rvalid_i  (data_rvalid_i),
    .data_addr_o    (data_addr_o),
    .data_we_o      (data_we_o),
    .data_be_o      (data_be_o),
    .data_wdata_o   (data_wdata_o),
    .ctrl_update_o  (ctrl_update),
    .lsu_ready_ex_o (lsu_ready_ex_o),
    .lsu_ready_wb_o (lsu_ready_wb_o),
    .busy_o         (busy_o)
  );

  //////////////////////////////////////////////////
  // wb side
  //////////////////////////////////////////////////

  assign wb_ctrl.data_type = ex_req_i.data_type;
  assign wb_ctrl.offset    = addr_off;
  assign wb_ctrl.sign_ext  = ex_req_i.sign_ext;
  assign wb_ctrl.we        = ex_req_i.we;

  lsu_response_stage u_rsp (
    .clk             (clk),
    .rst_n           (rst_n),
    .ctrl_update_i   (ctrl_update),
    .wb_ctrl_i       (wb_ctrl),
    .misaligned_ex_i (ex_req_i.misaligned),
    .misaligned_i    (data_misaligned_o),
    .data_rvalid_i   (data_rvalid_i),
    .data_rdata_i    (data_rdata_i),
    .rdata_o         (data_rdata_ex_o)
  );

endmodule

`default_nettype wire

// File: tb/lsu_mem_model.sv
// data memory model; 256 words wrap on addr[9:2], grant and rvalid delays are random but in order
`default_nettype none

module lsu_mem_model #(
  parameter int SEED = 84579  // start value for the delay generator
) (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           data_req_i,
  output logic           data_gnt_o,
  output logic           data_rvalid_o,
  input  lsu_pkg::addr_t data_addr_i,
  input  logic           data_we_i,
  input  lsu_pkg::be_t   data_be_i,
  input  lsu_pkg::data_t data_wdata_i,
  output lsu_pkg::data_t data_rdata_o,
  input  logic           hold_gnt_i,     // keep grant low while set
  input  int             rvalid_wait_i   // extra cycles before each response
);
  timeunit 1ns;
  timeprecision 100ps;

  lsu_pkg::data_t mem [0:255];
  lsu_pkg::data_t rsp_q[$];   // read data of accepted transactions
  int             wait_q[$];  // cycles left before each response
  int             seed;

  initial begin
    seed = SEED;
    for (int i = 0; i < 256; i++) begin
      mem[i] = (32'(i) * 32'h0101_0101) ^ 32'hC3A5_5A3C;  // every word differs
    end
  end

  always @(posedge clk or negedge rst_n) begin
    int idx;
    if (!rst_n) begin
      data_gnt_o    <= 1'b0;
      data_rvalid_o <= 1'b0;
      data_rdata_o  <= '0;
      rsp_q.delete();
      wait_q.delete();
    end else begin
      data_rvalid_o <= 1'b0;
      // oldest entry answers first
      if (rsp_q.size() > 0) begin
        if (wait_q[0] == 0) begin
          data_rvalid_o <= 1'b1;
          data_rdata_o  <= rsp_q.pop_front();
          void'(wait_q.pop_front());
        end else begin
          wait_q[0] = wait_q[0] - 1;
        end
      end
      if (data_req_i && data_gnt_o) begin  // accepted at this edge
        idx = int'(data_addr_i[9:2]);
        rsp_q.push_back(mem[idx]);         // word as it was before a write
        wait_q.push_back(rvalid_wait_i + int'($unsigned($random(seed)) % 3));
        if (data_we_i) begin
          for (int b = 0; b < 4; b++) begin
            if (data_be_i[b]) mem[idx][8*b +: 8] = data_wdata_i[8*b +: 8];
          end
        end
        data_gnt_o <= 1'b0;
      end else if (data_req_i && !hold_gnt_i) begin
        data_gnt_o <= 1'($random(seed));  // coin flip per waiting cycle
      end else begin
        data_gnt_o <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: tb/lsu_tb.sv
// directed lsu testbench; DEPTH 2, single memory model, all waits bounded by TIMEOUT cycles
`default_nettype none

module lsu_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int TIMEOUT = 200;  // cycles per access

  logic              clk;
  logic              rst_n;
  lsu_pkg::ex_req_t  ex_req;
  logic              data_misaligned;
  lsu_pkg::data_t    data_rdata_ex;
  logic              lsu_ready_ex;
  logic              lsu_ready_wb;
  logic              busy;
  logic              data_req;
  logic              data_gnt;
  logic              data_rvalid;
  lsu_pkg::addr_t    data_addr;
  logic              data_we;
  lsu_pkg::be_t      data_be;
  lsu_pkg::data_t    data_wdata;
  lsu_pkg::data_t    data_rdata;
  logic              hold_gnt;
  int                rvalid_wait;

  int                errors;
  int                timeouts;
  // what the bus showed at each grant, and the data of each response
  lsu_pkg::be_t      seen_be [2];
  lsu_pkg::data_t    seen_wdata [2];
  lsu_pkg::addr_t    seen_addr [2];
  logic              seen_we [2];
  logic              seen_mis [2];
  lsu_pkg::data_t    rsp [2];

  lsu_top #(.DEPTH(2)) dut0 (
    .clk (clk), .rst_n (rst_n), .ex_req_i (ex_req),
    .data_misaligned_o (data_misaligned), .data_rdata_ex_o (data_rdata_ex),
    .lsu_ready_ex_o (lsu_ready_ex), .lsu_ready_wb_o (lsu_ready_wb), .busy_o (busy),
    .data_req_o (data_req), .data_gnt_i (data_gnt), .data_rvalid_i (data_rvalid),
    .data_addr_o (data_addr), .data_we_o (data_we), .data_be_o (data_be),
    .data_wdata_o (data_wdata), .data_rdata_i (data_rdata)
  );

  lsu_mem_model #(.SEED(84579)) mem0 (
    .clk (clk), .rst_n (rst_n), .data_req_i (data_req), .data_gnt_o (data_gnt),
    .data_rvalid_o (data_rvalid), .data_addr_i (data_addr), .data_we_i (data_we),
    .data_be_i (data_be), .data_wdata_i (data_wdata), .data_rdata_o (data_rdata),
    .hold_gnt_i (hold_gnt), .rvalid_wait_i (rvalid_wait)
  );

  always #2 clk = ~clk;  // 4 ns period

  ////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////

  task automatic check_data(input string name, input lsu_pkg::data_t got,
      input lsu_pkg::data_t exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%08h expected 0x%08h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_be(input string name, input lsu_pkg::be_t got,
      input lsu_pkg::be_t exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%01h expected 0x%01h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%01h expected 0x%01h", name, got, exp);
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////

  // address is split into base plus increment so the adder is used
  function automatic lsu_pkg::ex_req_t make_req(input logic we, input lsu_pkg::data_type_e dt,
      input lsu_pkg::sign_ext_e se, input lsu_pkg::addr_t addr, input lsu_pkg::data_t wdata,
      input lsu_pkg::byte_off_t reg_off);
    lsu_pkg::ex_req_t r;
    r            = '0;
    r.req        = 1'b1;
    r.we         = we;
    r.data_type  = dt;
    r.sign_ext   = se;
    r.reg_offset = reg_off;
    r.operand_a  = addr & 32'hFFFF_FFF0;
    r.operand_b  = addr & 32'h0000_000F;
    r.use_incr   = 1'b1;
    r.wdata      = wdata;
    return r;
  endfunction

  // fill the upper bits of a loaded byte or halfword
  function automatic lsu_pkg::data_t extend(input lsu_pkg::data_t raw, input int bits,
      input lsu_pkg::sign_ext_e mode);
    logic fill;
    case (mode)
      lsu_pkg::ZERO_EXT: fill = 1'b0;
      lsu_pkg::ONES_EXT: fill = 1'b1;
      default:           fill = (bits == 8) ? raw[7] : raw[15];
    endcase
    if (bits == 8) return {{24{fill}}, raw[7:0]};
    return {{16{fill}}, raw[15:0]};
  endfunction

  // drive one or two parts, record each grant and response
  task automatic run_access(input lsu_pkg::ex_req_t p0, input lsu_pkg::ex_req_t p1,
      input int nparts, input int stall);
    lsu_pkg::ex_req_t parts [2];
    lsu_pkg::ex_req_t idle;
    int               issued;   // parts taken over by ex
    int               granted;  // parts accepted on the bus
    int               got;
    int               cyc;
    logic             advance;
    parts[0] = p0;
    parts[1] = p1;
    issued   = 0;
    granted  = 0;
    got      = 0;
    cyc      = 0;
    advance  = 1'b0;
    idle     = (nparts == 2) ? p1 : p0;  // keeps misaligned up for a late first rvalid
    idle.req = 1'b0;
    @(negedge clk);
    hold_gnt = (stall > 0);
    ex_req   = p0;
    for (int i = 0; i < stall; i++) begin  // grant held low
      @(negedge clk);
      check_bit("data_req_o", data_req, 1'b1);
      check_bit("lsu_ready_ex_o", lsu_ready_ex, 1'b0);
      check_bit("busy_o", busy, 1'b1);
    end
    hold_gnt = 1'b0;
    while (got < nparts && cyc < TIMEOUT) begin
      @(negedge clk);
      cyc++;
      // wb free with nothing outstanding, else only in a response cycle
      check_bit("lsu_ready_wb_o", lsu_ready_wb, data_rvalid || (granted == got));
      if (data_rvalid && got < 2) begin
        rsp[got] = data_rdata_ex;
        got++;
      end
      if (advance) begin  // ex took the part at the last edge
        ex_req  = (issued < nparts) ? parts[issued] : idle;
        advance = 1'b0;
      end else if (issued < nparts) begin
        if (granted == issued && data_req && data_gnt) begin
          seen_be[issued]    = data_be;
          seen_wdata[issued] = data_wdata;
          seen_addr[issued]  = data_addr;
          seen_we[issued]    = data_we;
          seen_mis[issued]   = data_misaligned;
          granted++;
        end
        if (lsu_ready_ex) begin  // part stays on ex_req until ex is ready
          issued++;
          advance = 1'b1;
        end
      end
    end
    if (got < nparts) begin
      $display("timeout: access at 0x%08h got %0d of %0d responses", p0.operand_a, got, nparts);
      timeouts++;
    end
    ex_req = idle;
  endtask

  task automatic single(input lsu_pkg::ex_req_t r);
    run_access(r, r, 1, 0);
  endtask

  task automatic store_word(input lsu_pkg::addr_t addr, input lsu_pkg::data_t w);
    single(make_req(1'b1, lsu_pkg::WORD, lsu_pkg::ZERO_EXT, addr, w, 2'd0));
  endtask

  ////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////

  task automatic check_idle();
    check_bit("data_req_o", data_req, 1'b0);
    check_bit("busy_o", busy, 1'b0);
    check_bit("lsu_ready_ex_o", lsu_ready_ex, 1'b1);
    check_bit("lsu_ready_wb_o", lsu_ready_wb, 1'b1);
  endtask

  task automatic test_aligned_word();
    store_word(32'h40, 32'h1234_5678);
    check_be("data_be_o", seen_be[0], 4'hF);
    check_data("data_wdata_o", seen_wdata[0], 32'h1234_5678);
    check_data("data_addr_o", seen_addr[0], 32'h40);
    check_bit("data_we_o store", seen_we[0], 1'b1);
    single(make_req(1'b0, lsu_pkg::WORD, lsu_pkg::ZERO_EXT, 32'h40, '0, 2'd0));
    check_bit("data_we_o load", seen_we[0], 1'b0);
    check_data("data_rdata_ex_o", rsp[0], 32'h1234_5678);
  endtask

  task automatic test_subword_stores();
    lsu_pkg::data_t base;
    lsu_pkg::data_t wval;
    lsu_pkg::data_t exp_wdata;
    lsu_pkg::data_t exp_word;
    lsu_pkg::be_t   exp_be;
    int             k;
    base = 32'hA5A5_5A5A;
    wval = 32'hC4B3_A291;
    for (int half = 0; half < 2; half++) begin
      for (int off = 0; off < 4 - half; off++) begin  // halfword at 3 would split
        for (int reg_off = 0; reg_off < 4; reg_off++) begin
          store_word(32'h80, base);
          single(make_req(1'b1, half ? lsu_pkg::HALF : lsu_pkg::BYTE, lsu_pkg::ZERO_EXT,
                          32'h80 + 32'(off), wval, 2'(reg_off)));
          k         = (off - reg_off) & 3;  // register lane reg_off lands on lane off
          exp_wdata = (wval << (8 * k)) | (wval >> (32 - 8 * k));
          exp_be    = half ? 4'(4'b0011 << off) : 4'(4'b0001 << off);
          for (int b = 0; b < 4; b++) begin
            exp_word[8*b +: 8] = exp_be[b] ? exp_wdata[8*b +: 8] : base[8*b +: 8];
          end
          check_be("data_be_o", seen_be[0], exp_be);
          check_data("data_wdata_o", seen_wdata[0], exp_wdata);
          single(make_req(1'b0, lsu_pkg::WORD, lsu_pkg::ZERO_EXT, 32'h80, '0, 2'd0));
          check_data("readback word", rsp[0], exp_word);
        end
      end
    end
  endtask

  task automatic test_subword_loads();
    lsu_pkg::data_t     w;
    lsu_pkg::sign_ext_e mode;
    w = 32'h8F7E_E180;  // bytes of both signs
    store_word(32'hC0, w);
    for (int m = 0; m < 3; m++) begin
      mode = lsu_pkg::sign_ext_e'(m);
      for (int off = 0; off < 4; off++) begin
        single(make_req(1'b0, lsu_pkg::BYTE, mode, 32'hC0 + 32'(off), '0, 2'd0));
        check_data("data_rdata_ex_o byte", rsp[0], extend(w >> (8 * off), 8, mode));
      end
      for (int off = 0; off < 3; off++) begin
        single(make_req(1'b0, lsu_pkg::HALF, mode, 32'hC0 + 32'(off), '0, 2'd0));
        check_data("data_rdata_ex_o half", rsp[0], extend(w >> (8 * off), 16, mode));
      end
    end
  endtask

  task automatic split_load(input lsu_pkg::data_type_e dt, input lsu_pkg::sign_ext_e se,
      input int off, input logic [63:0] pair);
    lsu_pkg::ex_req_t p0;
    lsu_pkg::ex_req_t p1;
    lsu_pkg::data_t   exp;
    p0            = make_req(1'b0, dt, se, 32'h100 + 32'(off), '0, 2'd0);
    p1            = p0;
    p1.operand_a  = p0.operand_a + 32'd4;  // same offset, next word
    p1.misaligned = 1'b1;
    run_access(p0, p1, 2, 0);
    exp = 32'(pair >> (8 * off));  // little endian span of both words
    if (dt == lsu_pkg::HALF) exp = extend(exp, 16, se);
    check_bit("data_misaligned_o first part", seen_mis[0], 1'b1);
    check_bit("data_misaligned_o second part", seen_mis[1], 1'b0);
    check_data("data_addr_o first part", seen_addr[0], 32'h100 + 32'(off));
    check_data("data_addr_o second part", seen_addr[1], 32'h104);
    if (dt == lsu_pkg::WORD) begin
      check_be("data_be_o first part", seen_be[0], 4'(4'hF << off));
      check_be("data_be_o second part", seen_be[1], 4'(4'hF >> (4 - off)));
    end else begin
      check_be("data_be_o first part", seen_be[0], 4'b1000);
      check_be("data_be_o second part", seen_be[1], 4'b0001);
    end
    check_data("data_rdata_ex_o split", rsp[1], exp);
  endtask

  task automatic test_misaligned();
    logic [63:0] pair;
    pair = 64'h8877_6655_4433_2211;
    store_word(32'h100, pair[31:0]);
    store_word(32'h104, pair[63:32]);
    for (int off = 1; off < 4; off++) split_load(lsu_pkg::WORD, lsu_pkg::ZERO_EXT, off, pair);
    split_load(lsu_pkg::HALF, lsu_pkg::SIGN_EXT, 3, pair);
    split_load(lsu_pkg::HALF, lsu_pkg::ONES_EXT, 3, pair);
  endtask

  task automatic test_backpressure();
    store_word(32'h140, 32'hDEAD_BEEF);
    store_word(32'h144, 32'h0BAD_F00D);
    rvalid_wait = 4;  // both loads in flight at once
    // second load differs in size and offset, so wb must switch control between them
    run_access(make_req(1'b0, lsu_pkg::WORD, lsu_pkg::ZERO_EXT, 32'h140, '0, 2'd0),
               make_req(1'b0, lsu_pkg::BYTE, lsu_pkg::SIGN_EXT, 32'h145, '0, 2'd0), 2, 6);
    rvalid_wait = 0;
    check_data("data_rdata_ex_o first load", rsp[0], 32'hDEAD_BEEF);
    check_data("data_rdata_ex_o second load", rsp[1], 32'hFFFF_FFF0);
  endtask

  ////////////////////////////////////////////////////
  // sequence
  ////////////////////////////////////////////////////

  initial begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    ex_req      = '0;
    hold_gnt    = 1'b0;
    rvalid_wait = 0;
    errors      = 0;
    timeouts    = 0;
    repeat (5) @(negedge clk);
    check_idle();  // inside reset
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_idle();
    test_aligned_word();
    test_subword_stores();
    test_subword_loads();
    test_misaligned();
    test_backpressure();
    repeat (4) @(negedge clk);
    $display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  initial begin  // guard against a stuck run
    #200000;
    $display("simulation time limit reached before the tests ended");
    $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire
